/* lb_subsys_top.f */
+incdir+hw
hw/lb_pkg.sv
hw/lb_bus_if.sv
hw/cdc_mcp_sync.sv
hw/lb_bridge.sv
hw/lb_reg_slave.sv
hw/lb_subsys_top.sv
verif/tb_clock_gen.sv
verif/lb_subsys_asserts.sv
verif/lb_subsys_tb.sv

/* verif/lb_subsys_tb.sv */
// local bus subsystem testbench: shadow register model, directed and random host requests
`timescale 1ns/10ps
`default_nettype none
`include "lb_macros.svh"

module lb_subsys_tb;

  // about 120 requests, each well under 30 lb_clk cycles
  localparam int NUM_REQS   = 120;
  localparam int REQ_CYCLES = 30;
  localparam int MAX_CYCLES = NUM_REQS * REQ_CYCLES + 400;
  localparam int NUM_ADDR   = 2 ** `LB_ADDR_WIDTH;

  logic                      hb_clk;
  logic                      lb_clk;
  logic                      rst_sync;
  logic                      hb_ren;
  logic                      hb_wen;
  logic [`LB_ADDR_WIDTH-1:0] hb_raddr;
  logic [`LB_ADDR_WIDTH-1:0] hb_waddr;
  logic [`LB_DATA_WIDTH-1:0] hb_wdata;
  lb_pkg::write_width_e      hb_write_width;
  logic                      hb_ready;
  logic [`LB_DATA_WIDTH-1:0] hb_rdata;
  logic                      hb_done;

  logic [`LB_DATA_WIDTH-1:0] shadow [NUM_ADDR];
  logic [31:0]               rng_state;
  int                        lb_cycles;

  tb_clock_gen #(.PERIOD_NS(100.0)) u_lb_clk (.clk(lb_clk));
  tb_clock_gen #(.PERIOD_NS(30.0)) u_hb_clk (.clk(hb_clk));

  lb_subsys_top UUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // bits a write of this width may change
  function automatic logic [`LB_DATA_WIDTH-1:0] lane_bits(input lb_pkg::write_width_e w);
    case (w)
      lb_pkg::WIDTH_BYTE: return 32'h0000_00ff;
      lb_pkg::WIDTH_HALF: return 32'h0000_ffff;
      default:            return 32'hffff_ffff;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic run_request(input logic ren, input logic wen,
                             input logic [`LB_ADDR_WIDTH-1:0] raddr,
                             input logic [`LB_ADDR_WIDTH-1:0] waddr,
                             input logic [`LB_DATA_WIDTH-1:0] wdata,
                             input lb_pkg::write_width_e width);
    logic [`LB_DATA_WIDTH-1:0] expected;
    logic [`LB_DATA_WIDTH-1:0] mask;
    @(negedge hb_clk);
    while (!hb_ready) @(negedge hb_clk);
    hb_ren         = ren;
    hb_wen         = wen;
    hb_raddr       = raddr;
    hb_waddr       = waddr;
    hb_wdata       = wdata;
    hb_write_width = width;
    @(negedge hb_clk);
    hb_ren = 1'b0;
    hb_wen = 1'b0;
    // read sees the bank from before this request's write
    expected = shadow[raddr];
    if (wen) begin
      mask          = lane_bits(width);
      shadow[waddr] = (shadow[waddr] & ~mask) | (wdata & mask);
    end
    while (!hb_done) @(negedge hb_clk);
    if (ren) begin
      assert (hb_rdata == expected)
        else abort_run($sformatf("CHECK FAILED at %0t: read 0x%0h gave 0x%08h, expected 0x%08h",
                                 $time, raddr, hb_rdata, expected));
    end
  endtask

  // cycle limit, and stop on the first bound assertion failure
  initial begin
    lb_cycles = 0;
    forever begin
      @(posedge lb_clk);
      lb_cycles++;
      if (UUT.u_asserts.fail_count != 0) begin
        abort_run("a bound protocol assertion fired");
      end
      if (lb_cycles >= MAX_CYCLES) begin
        abort_run("timeout: requests did not complete within the cycle limit");
      end
    end
  end

  initial begin
    logic [`LB_ADDR_WIDTH-1:0] a;
    logic [`LB_ADDR_WIDTH-1:0] b;
    logic [31:0]               r;
    rst_sync       = 1'b1;
    hb_ren         = 1'b0;
    hb_wen         = 1'b0;
    hb_raddr       = '0;
    hb_waddr       = '0;
    hb_wdata       = '0;
    hb_write_width = lb_pkg::WIDTH_WORD;
    rng_state      = 32'h591b;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (4) @(posedge lb_clk);
    @(negedge lb_clk);
    rst_sync = 1'b0;

    // every register starts at zero
    for (int i = 0; i < NUM_ADDR; i++) begin
      run_request(1'b1, 1'b0, i[`LB_ADDR_WIDTH-1:0], '0, '0, lb_pkg::WIDTH_WORD);
    end

    // word write and read back in each slave
    for (int s = 0; s < `LB_SLAVE_NUM; s++) begin
      r = next_rand();
      a = {s[1:0], r[3:0]};
      run_request(1'b0, 1'b1, '0, a, next_rand(), lb_pkg::WIDTH_WORD);
      run_request(1'b1, 1'b0, a, '0, '0, lb_pkg::WIDTH_WORD);
    end

    // narrow writes keep the upper bytes
    r = next_rand();
    a = r[`LB_ADDR_WIDTH-1:0];
    run_request(1'b0, 1'b1, '0, a, 32'ha1b2_c3d4, lb_pkg::WIDTH_WORD);
    run_request(1'b0, 1'b1, '0, a, 32'h5566_7788, lb_pkg::WIDTH_BYTE);
    run_request(1'b1, 1'b0, a, '0, '0, lb_pkg::WIDTH_WORD);
    run_request(1'b0, 1'b1, '0, a, 32'h99aa_bbcc, lb_pkg::WIDTH_HALF);
    run_request(1'b1, 1'b0, a, '0, '0, lb_pkg::WIDTH_WORD);

    // combined read and write, same address then another one
    run_request(1'b1, 1'b1, a, a, next_rand(), lb_pkg::WIDTH_WORD);
    run_request(1'b1, 1'b0, a, '0, '0, lb_pkg::WIDTH_WORD);
    b = a ^ 6'h25;
    run_request(1'b1, 1'b1, a, b, next_rand(), lb_pkg::WIDTH_RSVD);
    run_request(1'b1, 1'b0, b, '0, '0, lb_pkg::WIDTH_WORD);

    // random mix
    for (int n = 0; n < 30; n++) begin
      r = next_rand();
      run_request(r[0] | r[1], r[1] | ~r[0], r[7:2], r[13:8], next_rand(),
                  lb_pkg::write_width_e'(r[15:14]));
    end

    repeat (4) @(negedge lb_clk);
    if (UUT.u_asserts.fail_count != 0) begin
      abort_run("a bound protocol assertion fired");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/lb_subsys_asserts.sv */
// protocol checks on the subsystem: bus strobes, host handshake and completion pulse
`timescale 1ns/10ps
`default_nettype none

module lb_subsys_asserts (
  input logic hb_clk,
  input logic lb_clk,
  input logic rst_sync,
  input logic hb_ren,
  input logic hb_wen,
  input logic hb_ready,
  input logic hb_done,
  input logic bus_ren,
  input logic bus_wen
);

  int fail_count = 0;

  // one strobe at a time on the low-speed bus
  a_strobe_excl: assert property (@(posedge lb_clk) disable iff (rst_sync)
    !(bus_ren && bus_wen))
    else begin
      $error("bus ren and wen high together");
      fail_count++;
    end

  a_ren_single: assert property (@(posedge lb_clk) disable iff (rst_sync)
    bus_ren |=> !bus_ren)
    else begin
      $error("bus ren high for two cycles");
      fail_count++;
    end

  a_wen_single: assert property (@(posedge lb_clk) disable iff (rst_sync)
    bus_wen |=> !bus_wen)
    else begin
      $error("bus wen high for two cycles");
      fail_count++;
    end

  // read then write ends the strobe pair
  a_pair_end: assert property (@(posedge lb_clk) disable iff (rst_sync)
    bus_ren ##1 bus_wen |=> !(bus_ren || bus_wen))
    else begin
      $error("strobe pair longer than two cycles");
      fail_count++;
    end

  // completion only while a request is outstanding
  a_done_pulse: assert property (@(posedge hb_clk) disable iff (rst_sync)
    hb_done |-> !hb_ready ##1 !hb_done)
    else begin
      $error("hb_done outside a request or longer than one cycle");
      fail_count++;
    end

  // no queue in the bridge
  a_req_ready: assert property (@(posedge hb_clk) disable iff (rst_sync)
    (hb_ren || hb_wen) |-> hb_ready)
    else begin
      $error("host request while hb_ready low");
      fail_count++;
    end

  a_ready_fall: assert property (@(posedge hb_clk) disable iff (rst_sync)
    (hb_ren || hb_wen) |=> !hb_ready)
    else begin
      $error("hb_ready still high after a host request");
      fail_count++;
    end

  a_ready_reset: assert property (@(posedge hb_clk)
    $fell(rst_sync) |-> hb_ready)
    else begin
      $error("hb_ready low after reset");
      fail_count++;
    end

endmodule

bind lb_subsys_top lb_subsys_asserts u_asserts (
  .hb_clk  (hb_clk),
  .lb_clk  (lb_clk),
  .rst_sync(rst_sync),
  .hb_ren  (hb_ren),
  .hb_wen  (hb_wen),
  .hb_ready(hb_ready),
  .hb_done (hb_done),
  .bus_ren (bus_if.ren),
  .bus_wen (bus_if.wen)
);

`default_nettype wire

/* verif/tb_clock_gen.sv */
// testbench clock generator: free-running square wave with a set period
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* hw/lb_subsys_top.sv */
// local bus subsystem: bridge plus four register slaves behind plain host ports
`timescale 1ns/10ps
`default_nettype none
`include "lb_macros.svh"

module lb_subsys_top (
  input  logic                      hb_clk,
  input  logic                      lb_clk,
  input  logic                      rst_sync,

  input  logic                      hb_ren,
  input  logic                      hb_wen,
  input  logic [`LB_ADDR_WIDTH-1:0] hb_raddr,
  input  logic [`LB_ADDR_WIDTH-1:0] hb_waddr,
  input  logic [`LB_DATA_WIDTH-1:0] hb_wdata,
  input  lb_pkg::write_width_e      hb_write_width,
  output logic                      hb_ready,
  output logic [`LB_DATA_WIDTH-1:0] hb_rdata,
  output logic                      hb_done
);

  logic [`LB_DATA_WIDTH-1:0] slave_rdata [`LB_SLAVE_NUM];

  lb_bus_if bus_if ();

  lb_bridge u_bridge (
    .hb_clk        (hb_clk),
    .lb_clk        (lb_clk),
    .rst_sync      (rst_sync),
    .hb_ren        (hb_ren),
    .hb_wen        (hb_wen),
    .hb_raddr      (hb_raddr),
    .hb_waddr      (hb_waddr),
    .hb_wdata      (hb_wdata),
    .hb_write_width(hb_write_width),
    .hb_ready      (hb_ready),
    .hb_rdata      (hb_rdata),
    .hb_done       (hb_done),
    .bus           (bus_if),
    .slave_rdata   (slave_rdata)
  );

  // slave index is the top address field
  for (genvar g = 0; g < `LB_SLAVE_NUM; g++) begin : g_slave
    lb_reg_slave #(
      .SLAVE_ID(g)
    ) u_slave (
      .lb_clk  (lb_clk),
      .rst_sync(rst_sync),
      .bus     (bus_if),
      .rdata   (slave_rdata[g])
    );
  end

endmodule

`default_nettype wire

/* hw/lb_reg_slave.sv */
// register slave: one bank of lane-masked registers with a one-cycle read return
`timescale 1ns/10ps
`default_nettype none
`include "lb_macros.svh"

module lb_reg_slave #(
  parameter int SLAVE_ID = 0
) (
  input  logic                      lb_clk,
  input  logic                      rst_sync,
  lb_bus_if.slave                   bus,
  output logic [`LB_DATA_WIDTH-1:0] rdata
);

  localparam int SEL_W  = `LB_SEL_WIDTH;
  localparam int WORD_W = `LB_WORD_WIDTH;
  localparam int LANES  = `LB_DATA_WIDTH / 8;

  localparam logic [SEL_W-1:0] SLAVE_SEL = SEL_W'(SLAVE_ID);

  logic [`LB_DATA_WIDTH-1:0] regs [`LB_REGS_PER_SLAVE];
  logic                      hit;
  logic [WORD_W-1:0]         word;
  logic [LANES-1:0]          wmask;

  function automatic logic [LANES-1:0] lane_mask(lb_pkg::write_width_e width);
    case (width)
      lb_pkg::WIDTH_BYTE: return LANES'(1);
      lb_pkg::WIDTH_HALF: return LANES'(3);
      default:            return '1;
    endcase
  endfunction

  // slave field on top of the address
  assign hit   = (bus.addr[`LB_ADDR_WIDTH-1 -: SEL_W] == SLAVE_SEL);
  assign word  = bus.addr[WORD_W-1:0];
  assign wmask = lane_mask(bus.write_width);

  always_ff @(posedge lb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      for (int i = 0; i < `LB_REGS_PER_SLAVE; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.wen && hit) begin
      for (int b = 0; b < LANES; b++) begin
        if (wmask[b]) begin
          regs[word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // zero outside the cycle after a hit, so the bridge can OR all slaves
  always_ff @(posedge lb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      rdata <= '0;
    end else if (bus.ren && hit) begin
      rdata <= regs[word];
    end else begin
      rdata <= '0;
    end
  end

endmodule

`default_nettype wire

/* hw/lb_bridge.sv */
// local bus bridge: host request capture, clock crossings and the read-then-write bus sequencer
`timescale 1ns/10ps
`default_nettype none
`include "lb_macros.svh"

module lb_bridge (
  input  logic                      hb_clk,
  input  logic                      lb_clk,
  input  logic                      rst_sync,

  input  logic                      hb_ren,
  input  logic                      hb_wen,
  input  logic [`LB_ADDR_WIDTH-1:0] hb_raddr,
  input  logic [`LB_ADDR_WIDTH-1:0] hb_waddr,
  input  logic [`LB_DATA_WIDTH-1:0] hb_wdata,
  input  lb_pkg::write_width_e      hb_write_width,
  output logic                      hb_ready,
  output logic [`LB_DATA_WIDTH-1:0] hb_rdata,
  output logic                      hb_done,

  lb_bus_if.bridge                  bus,
  input  logic [`LB_DATA_WIDTH-1:0] slave_rdata [`LB_SLAVE_NUM]
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } lb_state_e;

  // host clock side
  lb_pkg::lb_req_t hb_req;
  lb_pkg::lb_rsp_t hb_rsp;
  logic            req_send;
  logic            req_send_ready;
  logic            hb_busy;
  logic            rsp_receive_ready;

  // bus clock side
  lb_pkg::lb_req_t           lb_req;
  lb_pkg::lb_rsp_t           lb_rsp;
  lb_state_e                 lb_state;
  logic                      req_receive_ready;
  logic                      receive;
  logic                      rsp_send_ready;
  logic                      lb_start;
  logic [`LB_DATA_WIDTH-1:0] rdata_mux;

  assign hb_req = '{
    ren:         hb_ren,
    wen:         hb_wen,
    raddr:       hb_raddr,
    waddr:       hb_waddr,
    wdata:       hb_wdata,
    write_width: hb_write_width
  };

  assign hb_ready = !hb_busy && req_send_ready;
  assign req_send = (hb_ren || hb_wen) && hb_ready;

  always_ff @(posedge hb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      hb_busy <= 1'b0;
      hb_done <= 1'b0;
    end else begin
      if (req_send) begin
        hb_busy <= 1'b1;
      end else if (hb_done) begin
        hb_busy <= 1'b0;
      end
      // one pulse per response, the ack lands while hb_done is high
      hb_done <= rsp_receive_ready && !hb_done;
    end
  end

  always_ff @(posedge hb_clk) begin
    if (rsp_receive_ready && !hb_done) begin
      hb_rdata <= hb_rsp.rdata;
    end
  end

  cdc_mcp_sync #(
    .payload_t(lb_pkg::lb_req_t)
  ) u_req_cdc (
    .clk_send     (hb_clk),
    .rst_send     (rst_sync),
    .send         (req_send),
    .send_ready   (req_send_ready),
    .data_in      (hb_req),
    .clk_receive  (lb_clk),
    .rst_receive  (rst_sync),
    .receive_ready(req_receive_ready),
    .receive      (receive),
    .data_out     (lb_req)
  );

  // slaves drive zero unless just read
  always_comb begin
    rdata_mux = '0;
    for (int i = 0; i < `LB_SLAVE_NUM; i++) begin
      rdata_mux = rdata_mux | slave_rdata[i];
    end
  end

  // receive still high in the first idle cycle, wait for the ack to clear ready
  assign lb_start = (lb_state == IDLE) && req_receive_ready && rsp_send_ready && !receive;

  assign bus.wdata       = lb_req.wdata;
  assign bus.write_width = lb_req.write_width;

  always_ff @(posedge lb_clk or posedge rst_sync) begin
    if (rst_sync) begin
      lb_state <= IDLE;
      bus.ren  <= 1'b0;
      bus.wen  <= 1'b0;
      receive  <= 1'b0;
    end else begin
      case (lb_state)
        IDLE: begin
          receive <= 1'b0;
          if (lb_start) begin
            // read goes first
            if (lb_req.ren) begin
              lb_state <= READ;
              bus.ren  <= 1'b1;
            end else if (lb_req.wen) begin
              lb_state <= WRITE;
              bus.wen  <= 1'b1;
            end else begin
              receive <= 1'b1;
            end
          end
        end
        READ: begin
          bus.ren  <= 1'b0;
          lb_state <= WRITE;
          bus.wen  <= lb_req.wen;
        end
        // also the capture cycle of a read-only request, strobe stays low then
        WRITE: begin
          bus.wen  <= 1'b0;
          lb_state <= IDLE;
          receive  <= 1'b1;
        end
        default: begin
          lb_state <= IDLE;
          bus.ren  <= 1'b0;
          bus.wen  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge lb_clk) begin
    if (lb_start) begin
      bus.addr <= lb_req.ren ? lb_req.raddr : lb_req.waddr;
      // write-only completions return zero
      if (!lb_req.ren) begin
        lb_rsp.rdata <= '0;
      end
    end else if (lb_state == READ) begin
      bus.addr <= lb_req.waddr;
    end else if (lb_state == WRITE && lb_req.ren) begin
      lb_rsp.rdata <= rdata_mux;
    end
  end

  // response leaves together with the request ack
  cdc_mcp_sync #(
    .payload_t(lb_pkg::lb_rsp_t)
  ) u_rsp_cdc (
    .clk_send     (lb_clk),
    .rst_send     (rst_sync),
    .send         (receive),
    .send_ready   (rsp_send_ready),
    .data_in      (lb_rsp),
    .clk_receive  (hb_clk),
    .rst_receive  (rst_sync),
    .receive_ready(rsp_receive_ready),
    .receive      (hb_done),
    .data_out     (hb_rsp)
  );

endmodule

`default_nettype wire

/* hw/cdc_mcp_sync.sv */
// multi-cycle-path crossing: held payload with request and ack toggles between two clocks
`timescale 1ns/10ps
`default_nettype none

module cdc_mcp_sync #(
  parameter type payload_t = logic
) (
  input  logic     clk_send,
  input  logic     rst_send,
  input  logic     send,
  output logic     send_ready,
  input  payload_t data_in,

  input  logic     clk_receive,
  input  logic     rst_receive,
  output logic     receive_ready,
  input  logic     receive,
  output payload_t data_out
);

  // send domain
  payload_t   hold_q;
  logic       send_toggle;
  logic [1:0] ack_sync;

  // receive domain
  logic [1:0] req_sync;
  logic       ack_toggle;

  // flip the request toggle once per accepted payload
  always_ff @(posedge clk_send or posedge rst_send) begin
    if (rst_send) begin
      send_toggle <= 1'b0;
    end else if (send && send_ready) begin
      send_toggle <= ~send_toggle;
    end
  end

  always_ff @(posedge clk_send) begin
    if (send && send_ready) begin
      hold_q <= data_in;
    end
  end

  // ack toggle back into the send domain
  always_ff @(posedge clk_send or posedge rst_send) begin
    if (rst_send) begin
      ack_sync <= 2'b00;
    end else begin
      ack_sync <= {ack_sync[0], ack_toggle};
    end
  end

  // free again once the ack has caught up with the request
  assign send_ready = (send_toggle == ack_sync[1]);

  always_ff @(posedge clk_receive or posedge rst_receive) begin
    if (rst_receive) begin
      req_sync <= 2'b00;
    end else begin
      req_sync <= {req_sync[0], send_toggle};
    end
  end

  always_ff @(posedge clk_receive or posedge rst_receive) begin
    if (rst_receive) begin
      ack_toggle <= 1'b0;
    end else if (receive && receive_ready) begin
      ack_toggle <= ~ack_toggle;
    end
  end

  // pending from the synced request edge until the receiver acks
  assign receive_ready = (req_sync[1] != ack_toggle);

  // hold_q stays put while receive_ready is high, so no per-bit sync
  assign data_out = hold_q;

endmodule

`default_nettype wire

/* hw/lb_bus_if.sv */
// low-speed bus bundle carrying strobes, address and write data from the bridge to the slaves
`timescale 1ns/10ps
`default_nettype none
`include "lb_macros.svh"

interface lb_bus_if;

  logic [`LB_ADDR_WIDTH-1:0] addr;
  logic                      ren;
  logic                      wen;
  logic [`LB_DATA_WIDTH-1:0] wdata;
  lb_pkg::write_width_e      write_width;

  // single driver, the sequencer in the bridge
  modport bridge (
    output addr,
    output ren,
    output wen,
    output wdata,
    output write_width
  );

  // every slave sees the whole bus and decodes its own address field
  modport slave (
    input addr,
    input ren,
    input wen,
    input wdata,
    input write_width
  );

endinterface

`default_nettype wire

/* hw/lb_pkg.sv */
// local bus bridge types: write width, request and response payloads
`default_nettype none
`include "lb_macros.svh"

package lb_pkg;

  // byte writes lane 0, half lanes 0-1, word all lanes
  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'd0,
    WIDTH_HALF = 2'd1,
    WIDTH_WORD = 2'd2,
    // decoded as a full word
    WIDTH_RSVD = 2'd3
  } write_width_e;

  // forward crossing payload
  typedef struct packed {
    logic                      ren;
    logic                      wen;
    logic [`LB_ADDR_WIDTH-1:0] raddr;
    logic [`LB_ADDR_WIDTH-1:0] waddr;
    logic [`LB_DATA_WIDTH-1:0] wdata;
    write_width_e              write_width;
  } lb_req_t;

  // return crossing payload
  typedef struct packed {
    logic [`LB_DATA_WIDTH-1:0] rdata;
  } lb_rsp_t;

endpackage

`default_nettype wire

/* hw/lb_macros.svh */
// low-speed bus parameters: address split, slave count, bank depth and data width
`ifndef LB_MACROS_SVH
`define LB_MACROS_SVH

// top bits pick the slave, low bits pick the word
`define LB_ADDR_WIDTH 6

`define LB_SLAVE_NUM 4

`define LB_REGS_PER_SLAVE 16

`define LB_DATA_WIDTH 32

// derived address fields
`define LB_SEL_WIDTH $clog2(`LB_SLAVE_NUM)

`define LB_WORD_WIDTH (`LB_ADDR_WIDTH - `LB_SEL_WIDTH)

`endif
